// File: hdl/segre_pkg.sv
package segre_pkg;

    // Datapath sizes
    localparam int ADDR_SIZE        = 32;
    localparam int WORD_SIZE        = 32;
    localparam int REG_ADDR_SIZE    = 5;
    localparam int NUM_REGS         = 2 ** REG_ADDR_SIZE;
    localparam int DCACHE_LANE_SIZE = 128;

    // Lane layout, shared by the instruction cache and main memory
    localparam int LANE_WORDS       = DCACHE_LANE_SIZE / WORD_SIZE;
    localparam int WORD_OFFSET_SIZE = $clog2(WORD_SIZE / 8);
    localparam int WORD_SEL_SIZE    = $clog2(LANE_WORDS);
    localparam int LANE_OFFSET_SIZE = WORD_OFFSET_SIZE + WORD_SEL_SIZE;

    // Instruction cache geometry
    localparam int ICACHE_LANES      = 4;
    localparam int ICACHE_INDEX_SIZE = $clog2(ICACHE_LANES);
    localparam int ICACHE_TAG_SIZE   = ADDR_SIZE - ICACHE_INDEX_SIZE - LANE_OFFSET_SIZE;

    // Supported RISC-V opcodes
    localparam logic [6:0] OPCODE_OP    = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    // MMU state encoding
    localparam logic [1:0] MMU_IDLE    = 2'd0;
    localparam logic [1:0] MMU_BUSY_RD = 2'd1;
    localparam logic [1:0] MMU_BUSY_WR = 2'd2;

    // One instruction word, two decodes
    typedef union packed {
        // ADD, ADDI and LUI; immediates are rebuilt from these fields
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
        // Store with its split immediate
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
    } instr_t;

endpackage : segre_pkg

// File: hdl/segre_mmu_if.sv
interface segre_mmu_if;

    logic                                   rd_req;
    logic                                   wr_req;
    logic [segre_pkg::ADDR_SIZE-1:0]        addr;
    logic [segre_pkg::WORD_SIZE-1:0]        wr_data;
    logic                                   rdy;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] rd_lane;

    modport requester (
        output rd_req,
        output wr_req,
        output addr,
        output wr_data,
        input  rdy,
        input  rd_lane
    );

    modport mmu (
        input  rd_req,
        input  wr_req,
        input  addr,
        input  wr_data,
        output rdy,
        output rd_lane
    );

endinterface : segre_mmu_if

// File: hdl/segre_if_stage.sv
module segre_if_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              ex_ready_i,
    output segre_pkg::instr_t instr_o,
    output logic              instr_valid_o,
    segre_mmu_if.requester    mmu
);

    logic [segre_pkg::ADDR_SIZE-1:0] pc_q;

    // Direct-mapped cache storage
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lanes_q [segre_pkg::ICACHE_LANES];
    logic [segre_pkg::ICACHE_TAG_SIZE-1:0]  tags_q  [segre_pkg::ICACHE_LANES];
    logic [segre_pkg::ICACHE_LANES-1:0]     valid_q;

    logic [segre_pkg::ICACHE_INDEX_SIZE-1:0] index;
    logic [segre_pkg::ICACHE_TAG_SIZE-1:0]   tag;
    logic [segre_pkg::WORD_SEL_SIZE-1:0]     word_sel;
    logic                                    hit;
    logic                                    take;
    logic                                    load;
    logic                                    rd_req_q;

    segre_pkg::instr_t instr_q;
    logic              instr_valid_q;

    assign index    = pc_q[segre_pkg::LANE_OFFSET_SIZE +: segre_pkg::ICACHE_INDEX_SIZE];
    assign tag      = pc_q[segre_pkg::ADDR_SIZE-1 -: segre_pkg::ICACHE_TAG_SIZE];
    assign word_sel = pc_q[segre_pkg::WORD_OFFSET_SIZE +: segre_pkg::WORD_SEL_SIZE];
    assign hit      = valid_q[index] && (tags_q[index] == tag);

    // Execute accepts the held instruction
    assign take = instr_valid_q && ex_ready_i;
    // Output register is empty and the lookup hits
    assign load = !instr_valid_q && hit;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q          <= '0;
            instr_valid_q <= 1'b0;
        end else if (take) begin
            pc_q          <= pc_q + (segre_pkg::ADDR_SIZE)'(4);
            instr_valid_q <= 1'b0;
        end else if (load) begin
            instr_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            instr_q <= lanes_q[index][word_sel*segre_pkg::WORD_SIZE +: segre_pkg::WORD_SIZE];
        end
    end

    // Refill on a miss; retry happens once the lane is valid
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            rd_req_q <= 1'b0;
        end else if (rd_req_q) begin
            if (mmu.rdy) begin
                rd_req_q       <= 1'b0;
                valid_q[index] <= 1'b1;
            end
        end else if (!instr_valid_q && !hit) begin
            rd_req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_req_q && mmu.rdy) begin
            lanes_q[index] <= mmu.rd_lane;
            tags_q[index]  <= tag;
        end
    end

    // Lane-aligned refill address, held by the stalled pc
    assign mmu.addr    = {pc_q[segre_pkg::ADDR_SIZE-1:segre_pkg::LANE_OFFSET_SIZE],
                          {segre_pkg::LANE_OFFSET_SIZE{1'b0}}};
    assign mmu.rd_req  = rd_req_q;
    assign mmu.wr_req  = 1'b0;
    assign mmu.wr_data = '0;

    assign instr_o       = instr_q;
    assign instr_valid_o = instr_valid_q;

endmodule : segre_if_stage

// File: hdl/segre_register_file.sv
module segre_register_file (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_a_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] raddr_b_i,
    input  logic [segre_pkg::REG_ADDR_SIZE-1:0] waddr_i,
    input  logic                                we_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     wdata_i,
    output logic [segre_pkg::WORD_SIZE-1:0]     data_a_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     data_b_o
);

    logic [segre_pkg::WORD_SIZE-1:0] regs_q [segre_pkg::NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < segre_pkg::NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign data_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign data_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule : segre_register_file

// File: hdl/segre_ex_stage.sv
module segre_ex_stage (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  segre_pkg::instr_t                   instr_i,
    input  logic                                instr_valid_i,
    output logic                                ex_ready_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b_o,
    input  logic [segre_pkg::WORD_SIZE-1:0]     rf_data_a_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]     rf_data_b_i,
    output logic                                rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]     rf_wdata_o,
    segre_mmu_if.requester                      mmu
);

    logic ready_q;
    logic wr_req_q;
    logic is_add;
    logic is_addi;
    logic is_lui;
    logic is_store;

    logic [segre_pkg::WORD_SIZE-1:0] i_imm;
    logic [segre_pkg::WORD_SIZE-1:0] u_imm;
    logic [segre_pkg::WORD_SIZE-1:0] s_imm;

    assign is_add   = instr_valid_i && (instr_i.i.opcode == segre_pkg::OPCODE_OP) &&
                      (instr_i.i.funct3 == segre_pkg::FUNCT3_ADD) && (instr_i.i.funct7 == '0);
    assign is_addi  = instr_valid_i && (instr_i.i.opcode == segre_pkg::OPCODE_OPIMM) &&
                      (instr_i.i.funct3 == segre_pkg::FUNCT3_ADD);
    assign is_lui   = instr_valid_i && (instr_i.i.opcode == segre_pkg::OPCODE_LUI);
    assign is_store = instr_valid_i && (instr_i.s.opcode == segre_pkg::OPCODE_STORE) &&
                      (instr_i.s.funct3 == segre_pkg::FUNCT3_SW);

    // I-type immediate sits in the funct7 and rs2 fields
    assign i_imm = {{(segre_pkg::WORD_SIZE-12){instr_i.i.funct7[6]}},
                    instr_i.i.funct7, instr_i.i.rs2};
    assign u_imm = {instr_i.i.funct7, instr_i.i.rs2, instr_i.i.rs1, instr_i.i.funct3, 12'b0};
    assign s_imm = {{(segre_pkg::WORD_SIZE-12){instr_i.s.imm_hi[6]}},
                    instr_i.s.imm_hi, instr_i.s.imm_lo};

    assign rf_raddr_a_o = instr_i.i.rs1;
    assign rf_raddr_b_o = instr_i.s.rs2;
    assign rf_waddr_o   = instr_i.i.rd;
    assign rf_we_o      = ready_q && (is_add || is_addi || is_lui);

    always_comb begin
        if (is_lui) begin
            rf_wdata_o = u_imm;
        end else if (is_addi) begin
            rf_wdata_o = rf_data_a_i + i_imm;
        end else begin
            rf_wdata_o = rf_data_a_i + rf_data_b_i;
        end
    end

    // Stores hold the instruction until the MMU answers
    assign ex_ready_o = ready_q && (!is_store || mmu.rdy);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ready_q  <= 1'b0;
            wr_req_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (wr_req_q) begin
                if (mmu.rdy) begin
                    wr_req_q <= 1'b0;
                end
            end else if (is_store && ready_q) begin
                wr_req_q <= 1'b1;
            end
        end
    end

    // Operands stay stable while the store waits, no register writes meanwhile
    assign mmu.addr    = rf_data_a_i + s_imm;
    assign mmu.wr_data = rf_data_b_i;
    assign mmu.wr_req  = wr_req_q;
    assign mmu.rd_req  = 1'b0;

endmodule : segre_ex_stage

// File: hdl/segre_mmu.sv
module segre_mmu (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    segre_mmu_if.mmu                               ic,
    segre_mmu_if.mmu                               dc,
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o
);

    logic [1:0] state_q;
    logic       owner_dc_q;
    logic       ic_rdy_q;
    logic       dc_rdy_q;
    logic       ic_pend;
    logic       dc_pend;
    logic       accept;

    logic [segre_pkg::ADDR_SIZE-1:0]        addr_q;
    logic [segre_pkg::WORD_SIZE-1:0]        word_q;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lane_q;
    logic [segre_pkg::WORD_SEL_SIZE-1:0]    slot;

    assign ic_pend = ic.rd_req || ic.wr_req;
    assign dc_pend = dc.rd_req || dc.wr_req;
    // A request is still high during its own rdy pulse
    assign accept  = (state_q == segre_pkg::MMU_IDLE) && !ic_rdy_q && !dc_rdy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= segre_pkg::MMU_IDLE;
            owner_dc_q <= 1'b0;
            ic_rdy_q   <= 1'b0;
            dc_rdy_q   <= 1'b0;
        end else begin
            ic_rdy_q <= 1'b0;
            dc_rdy_q <= 1'b0;
            case (state_q)
                segre_pkg::MMU_IDLE: begin
                    // Data side first
                    if (accept && dc_pend) begin
                        state_q    <= dc.wr_req ? segre_pkg::MMU_BUSY_WR : segre_pkg::MMU_BUSY_RD;
                        owner_dc_q <= 1'b1;
                    end else if (accept && ic_pend) begin
                        state_q    <= ic.wr_req ? segre_pkg::MMU_BUSY_WR : segre_pkg::MMU_BUSY_RD;
                        owner_dc_q <= 1'b0;
                    end
                end
                segre_pkg::MMU_BUSY_RD, segre_pkg::MMU_BUSY_WR: begin
                    if (mm_data_rdy_i) begin
                        state_q  <= segre_pkg::MMU_IDLE;
                        ic_rdy_q <= !owner_dc_q;
                        dc_rdy_q <= owner_dc_q;
                    end
                end
                default: state_q <= segre_pkg::MMU_IDLE;
            endcase
        end
    end

    // Request holder for the winner
    always_ff @(posedge clk_i) begin
        if (accept && dc_pend) begin
            addr_q <= dc.addr;
            word_q <= dc.wr_data;
        end else if (accept && ic_pend) begin
            addr_q <= ic.addr;
            word_q <= ic.wr_data;
        end
        if ((state_q == segre_pkg::MMU_BUSY_RD) && mm_data_rdy_i) begin
            lane_q <= mm_rd_data_i;
        end
    end

    // Store word goes into its lane slot, other slots zero
    assign slot = addr_q[segre_pkg::WORD_OFFSET_SIZE +: segre_pkg::WORD_SEL_SIZE];

    always_comb begin
        mm_wr_data_o = '0;
        for (int w = 0; w < segre_pkg::LANE_WORDS; w++) begin
            if (slot == w) begin
                mm_wr_data_o[w*segre_pkg::WORD_SIZE +: segre_pkg::WORD_SIZE] = word_q;
            end
        end
    end

    assign mm_rd_o      = (state_q == segre_pkg::MMU_BUSY_RD);
    assign mm_wr_o      = (state_q == segre_pkg::MMU_BUSY_WR);
    assign mm_addr_o    = addr_q;
    assign mm_wr_addr_o = addr_q;

    assign ic.rdy     = ic_rdy_q;
    assign dc.rdy     = dc_rdy_q;
    assign ic.rd_lane = lane_q;
    assign dc.rd_lane = lane_q;

endmodule : segre_mmu

// File: hdl/segre_core.sv
module segre_core (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    // Main memory
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o
);

    segre_mmu_if ic_mmu ();
    segre_mmu_if dc_mmu ();

    segre_pkg::instr_t instr;
    logic              instr_valid;
    logic              ex_ready;

    logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_a;
    logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_raddr_b;
    logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr;
    logic [segre_pkg::WORD_SIZE-1:0]     rf_data_a;
    logic [segre_pkg::WORD_SIZE-1:0]     rf_data_b;
    logic [segre_pkg::WORD_SIZE-1:0]     rf_wdata;
    logic                                rf_we;

    segre_if_stage if_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ex_ready_i    (ex_ready),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .mmu           (ic_mmu.requester)
    );

    segre_register_file segre_rf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .waddr_i   (rf_waddr),
        .we_i      (rf_we),
        .wdata_i   (rf_wdata),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b)
    );

    segre_ex_stage ex_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .ex_ready_o    (ex_ready),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .mmu           (dc_mmu.requester)
    );

    segre_mmu mmu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ic            (ic_mmu.mmu),
        .dc            (dc_mmu.mmu),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

endmodule : segre_core

// File: testbench/segre_core_chk.sv
module segre_core_chk (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            mm_data_rdy_i,
    input logic [segre_pkg::ADDR_SIZE-1:0] mm_addr_o,
    input logic [segre_pkg::ADDR_SIZE-1:0] mm_wr_addr_o,
    input logic                            mm_rd_o,
    input logic                            mm_wr_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // One main-memory access at a time
    rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mm_rd_o && mm_wr_o))
        else $error("mm_rd_o and mm_wr_o are high in the same cycle");

    // Request and address held until the memory answers
    rd_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mm_rd_o && !mm_data_rdy_i) |=> (mm_rd_o && $stable(mm_addr_o)))
        else $error("read request dropped or mm_addr_o changed before mm_data_rdy_i");

    wr_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mm_wr_o && !mm_data_rdy_i) |=> (mm_wr_o && $stable(mm_wr_addr_o)))
        else $error("write request dropped or mm_wr_addr_o changed before mm_data_rdy_i");

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |=> (!mm_rd_o && !mm_wr_o))
        else $error("main-memory request high in the first cycle after reset");

endmodule : segre_core_chk

bind segre_core segre_core_chk chk (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mm_data_rdy_i (mm_data_rdy_i),
    .mm_addr_o     (mm_addr_o),
    .mm_wr_addr_o  (mm_wr_addr_o),
    .mm_rd_o       (mm_rd_o),
    .mm_wr_o       (mm_wr_o)
);

// File: testbench/segre_core_tb.sv
module segre_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 4;
    localparam int          TIMEOUT      = 2000;
    localparam int          RAW_WORDS    = 64;
    localparam int          IMAGE_WORDS  = 32;
    localparam int          PROG_WORDS   = 16;
    localparam int          STORE_BASE   = 'h20;
    localparam int          LANE_BYTES   = segre_pkg::DCACHE_LANE_SIZE / 8;
    localparam logic [31:0] SEED         = 32'h1622ec3b;

    logic                                   clk_i;
    logic                                   rst_n_i;
    logic                                   mm_data_rdy_i;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_wr_data_o;
    logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o;
    logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o;
    logic                                   mm_rd_o;
    logic                                   mm_wr_o;

    logic [31:0]                     raw_words [RAW_WORDS];
    logic [segre_pkg::WORD_SIZE-1:0] prog_image [IMAGE_WORDS];
    logic [segre_pkg::ADDR_SIZE-1:0] exp_addr [$];
    logic [segre_pkg::WORD_SIZE-1:0] exp_data [$];

    int          n_stores;
    int          stores_seen;
    int          reads_seen;
    logic [31:0] rand_state;

    segre_core uut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_wr_data_o  (mm_wr_data_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input logic [segre_pkg::ADDR_SIZE-1:0] got,
                              input logic [segre_pkg::ADDR_SIZE-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [segre_pkg::WORD_SIZE-1:0] got,
                              input logic [segre_pkg::WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lane of the program image with zeros past its end
    function automatic logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lane_at(
        input logic [segre_pkg::ADDR_SIZE-1:0] addr);
        logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lane;
        longint                                 base;
        lane = '0;
        base = longint'(addr >> segre_pkg::LANE_OFFSET_SIZE) * segre_pkg::LANE_WORDS;
        for (int w = 0; w < segre_pkg::LANE_WORDS; w++) begin
            if (base + w < IMAGE_WORDS) begin
                lane[w*segre_pkg::WORD_SIZE +: segre_pkg::WORD_SIZE] = prog_image[base + w];
            end
        end
        return lane;
    endfunction

    task automatic load_patterns();
        for (int i = 0; i < RAW_WORDS; i++) begin
            raw_words[i] = '0;
        end
        $readmemh("testbench/core_patterns.mem", raw_words);
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            prog_image[i] = raw_words[i];
        end
        n_stores = int'(raw_words[STORE_BASE]);
        if (n_stores < 1 || STORE_BASE + 2 * n_stores >= RAW_WORDS) begin
            fail_run("The pattern file holds no usable list of expected stores");
        end else begin
            for (int k = 0; k < n_stores; k++) begin
                exp_addr.push_back(raw_words[STORE_BASE + 1 + 2 * k]);
                exp_data.push_back(raw_words[STORE_BASE + 2 + 2 * k]);
            end
        end
    endtask

    // Random latency of 1 to 6 cycles, then a one-cycle ready pulse
    task automatic respond(input logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lane);
        int delay;
        rand_state = lcg_step(rand_state);
        delay      = 1 + int'(rand_state[31:16]) % 6;
        repeat (delay) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
        mm_rd_data_i  = lane;
        mm_data_rdy_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        mm_data_rdy_i = 1'b0;
    endtask

    task automatic check_store();
        logic [segre_pkg::WORD_SIZE-1:0] slot_exp;
        check_addr("mm_wr_addr_o", mm_wr_addr_o, exp_addr[stores_seen]);
        // Only the slot picked by address bits 3:2 carries the word
        for (int s = 0; s < segre_pkg::LANE_WORDS; s++) begin
            slot_exp = (exp_addr[stores_seen][3:2] == 2'(s)) ? exp_data[stores_seen] : '0;
            check_word($sformatf("mm_wr_data_o word %0d", s),
                       mm_wr_data_o[s*segre_pkg::WORD_SIZE +: segre_pkg::WORD_SIZE], slot_exp);
        end
    endtask

    task automatic serve_memory();
        int waited;
        forever begin
            waited = 0;
            do begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                waited++;
            end while (!(mm_rd_o || mm_wr_o) && waited < TIMEOUT);
            if (!(mm_rd_o || mm_wr_o)) begin
                fail_run("Timeout: main memory saw no read or write request for 2000 cycles");
            end else if (mm_rd_o) begin
                // Reads walk the lanes in order, so each lane is fetched once
                check_addr("mm_addr_o", mm_addr_o,
                           (segre_pkg::ADDR_SIZE)'(reads_seen * LANE_BYTES));
                reads_seen++;
                respond(lane_at(mm_addr_o));
            end else if (stores_seen >= n_stores) begin
                fail_run($sformatf("A store to 0x%08h came after all expected stores",
                                   mm_wr_addr_o));
            end else begin
                check_store();
                stores_seen++;
                respond('0);
            end
        end
    endtask

    task automatic wait_for_stores();
        int waited;
        waited = 0;
        while (stores_seen < n_stores && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (stores_seen < n_stores) begin
            fail_run($sformatf("Timeout: only %0d of %0d expected stores reached main memory",
                               stores_seen, n_stores));
        end
    endtask

    // A refill past the program means every instruction has run
    task automatic wait_for_program_end();
        int waited;
        waited = 0;
        while (reads_seen <= PROG_WORDS / segre_pkg::LANE_WORDS && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (reads_seen <= PROG_WORDS / segre_pkg::LANE_WORDS) begin
            fail_run("Timeout: fetch never requested the lane after the program");
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        mm_data_rdy_i = 1'b0;
        mm_rd_data_i  = '0;
        stores_seen   = 0;
        reads_seen    = 0;
        rand_state    = SEED;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        fork
            serve_memory();
        join_none
        wait_for_stores();
        wait_for_program_end();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : segre_core_tb

// File: verilog.f
hdl/segre_pkg.sv
hdl/segre_mmu_if.sv
hdl/segre_if_stage.sv
hdl/segre_register_file.sv
hdl/segre_ex_stage.sv
hdl/segre_mmu.sv
hdl/segre_core.sv
testbench/segre_core_chk.sv
testbench/segre_core_tb.sv

// File: Makefile
TOP = segre_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: testbench/core_patterns.mem
// Words 00-0f: program, one instruction word per line
// Word 20: number of stores, then one line per store with address and data
000010b7 // lui  x1, 0x00001
12300113 // addi x2, x0, 0x123
0020a223 // sw   x2, 4(x1)
fffff1b7 // lui  x3, 0xfffff
fff18213 // addi x4, x3, -1
002202b3 // add  x5, x4, x2
fe50ac23 // sw   x5, -8(x1)
80000337 // lui  x6, 0x80000
006303b3 // add  x7, x6, x6
7ff38393 // addi x7, x7, 0x7ff
00328433 // add  x8, x5, x3
0080a623 // sw   x8, 12(x1)
05500013 // addi x0, x0, 0x55
007004b3 // add  x9, x0, x7
7e90aa23 // sw   x9, 0x7f4(x1)
8060a023 // sw   x6, -2048(x1)
@20
00000005
00001004 00000123
00000ff8 fffff122
0000100c ffffe122
000017f4 000007ff
00000800 80000000
